// File: include/tdc_defs.svh
`ifndef TDC_DEFS_SVH
`define TDC_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// geometry
////////////////////////////////////////////////////////////////////////////

// number of hit channels
`define TDC_CHANNELS 4
// timestamps held per channel FIFO
`define TDC_FIFO_DEPTH 8
// free-running counter width
`define TDC_TS_WIDTH 64
// bus word address width
`define TDC_ADR_WIDTH 6

// constant seen at the ID register
`define TDC_ID_WORD 32'hdeadbeef

////////////////////////////////////////////////////////////////////////////
// register map, word addresses
////////////////////////////////////////////////////////////////////////////

`define TDC_REG_ID 6'd0
`define TDC_REG_TRIG_HI 6'd1
`define TDC_REG_TRIG_LO 6'd2
// empty flags in 3..0, full flags in 7..4
`define TDC_REG_STATUS 6'd3
// bit 0 drives the trigger pin
`define TDC_REG_CTRL 6'd4
// write-only, one pop bit per channel
`define TDC_REG_POP 6'd5
// channel c head at base + 2c (high word) and base + 2c + 1 (low word)
`define TDC_REG_HEAD_BASE 6'd8

`endif

// File: project.f
+incdir+include
verilog/tdc_pkg.sv
verilog/hit_sync.sv
verilog/timestamp_unit.sv
verilog/channel_fifo.sv
verilog/wb_readout.sv
verilog/tdc_top.sv
tb/tdc_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the timestamper testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tdc_tb -f project.f \
    -Mdir obj_dir -o tdc_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tdc_sim > sim.log 2>&1
grep -q "Simulation completed successfully" sim.log \
    && echo "PASS" \
    || { echo "FAIL, see sim.log"; exit 1; }

// File: tb/tdc_tb.sv
`timescale 1ns/1ns
`include "tdc_defs.svh"

module tdc_tb
    import tdc_pkg::*;
();

    // bus polls before giving up on an ack
    localparam int bus_timeout = 20;
    // status reads before giving up on a hit
    localparam int poll_limit = 50;

    logic       clk200;
    logic       counter_reset;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    bus_adr_t   wb_adr;
    bus_word_t  wb_dat_w;
    bus_word_t  wb_dat_r;
    logic       wb_ack;
    chan_mask_t hit_in;
    logic       trigger_out;

    int errors = 0;
    int checks = 0;
    int tests_run = 0;
    // galois shift register for hit gaps
    logic [31:0] lfsr_state = 32'h346f_3dd0;

    // 10 ns period
    initial
    begin
        clk200 = 1'b0;
        forever #5 clk200 = ~clk200;
    end

    tdc_top UUT (
        .clk200        (clk200),
        .counter_reset (counter_reset),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat_w      (wb_dat_w),
        .wb_dat_r      (wb_dat_r),
        .wb_ack        (wb_ack),
        .hit_in        (hit_in),
        .trigger_out   (trigger_out)
    );

    ////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////

    task automatic report_failure(input string reason);
        errors++;
        $display("ERROR: %s", reason);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    // one shift per bit taken, msb of the result is the oldest bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] value;
        logic        lsb;
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            lsb = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (lsb)
                lfsr_state = lfsr_state ^ 32'ha300_0000;
            value = {value[30:0], lsb};
        end
        return value;
    endfunction

    // full flags above empty flags
    function automatic bus_word_t status_word(input chan_mask_t full_m,
                                              input chan_mask_t empty_m);
        return {24'h0, full_m, empty_m};
    endfunction

    // one classic cycle, driven and sampled on falling edges
    task automatic bus_access(input logic we, input bus_adr_t adr,
                              input bus_word_t wdata, output bus_word_t rdata);
        int waited;
        waited = 0;
        @(negedge clk200);
        // previous ack lasted a single cycle
        check_value("wb_ack idle", wb_ack, 1'b0);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        do
        begin
            @(negedge clk200);
            waited++;
        end
        while (!wb_ack && waited < bus_timeout);
        if (!wb_ack)
            report_failure($sformatf("no ack for access at address %0d", adr));
        else
            check_value("wb_ack latency", waited, 1);
        rdata  = wb_dat_r;
        // drop the strobe on the ack cycle
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input bus_adr_t adr, output bus_word_t data);
        bus_access(1'b0, adr, '0, data);
    endtask

    task automatic wb_write(input bus_adr_t adr, input bus_word_t data);
        bus_word_t unused;
        bus_access(1'b1, adr, data, unused);
    endtask

    // hits high for 2 cycles, rising edges gap cycles apart
    task automatic hit_train(input chan_mask_t mask, input int count, input int gap);
        @(negedge clk200);
        for (int i = 0; i < count; i++)
        begin
            hit_in = hit_in | mask;
            repeat (2) @(negedge clk200);
            hit_in = hit_in & ~mask;
            repeat (gap - 2) @(negedge clk200);
        end
    endtask

    task automatic wait_not_empty(input int ch);
        bus_word_t st;
        int        polls;
        polls = 0;
        wb_read(`TDC_REG_STATUS, st);
        while (st[ch] && polls < poll_limit)
        begin
            wb_read(`TDC_REG_STATUS, st);
            polls++;
        end
        if (st[ch])
            report_failure($sformatf("channel %0d never received a timestamp", ch));
    endtask

    // high word sits at the even address
    task automatic read_head(input int ch, output timestamp_t ts);
        bus_word_t hi;
        bus_word_t lo;
        wb_read(bus_adr_t'(`TDC_REG_HEAD_BASE + 2 * ch), hi);
        wb_read(bus_adr_t'(`TDC_REG_HEAD_BASE + 2 * ch + 1), lo);
        ts = {hi, lo};
    endtask

    task automatic read_trig(output timestamp_t ts);
        bus_word_t hi;
        bus_word_t lo;
        wb_read(`TDC_REG_TRIG_HI, hi);
        wb_read(`TDC_REG_TRIG_LO, lo);
        ts = {hi, lo};
    endtask

    task automatic end_test(input int num, input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before)
            $display("test %0d %s: ok", num, name);
        else
            $display("test %0d %s: %0d errors", num, name, errors - errs_before);
    endtask

    ////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////

    task automatic id_and_reset_state();
        bus_word_t rd;
        int        errs_before;
        errs_before = errors;
        wb_read(`TDC_REG_ID, rd);
        check_value("wb_dat_r id", rd, `TDC_ID_WORD);
        wb_read(`TDC_REG_STATUS, rd);
        check_value("wb_dat_r status", rd, status_word(4'h0, 4'hf));
        check_value("trigger_out", trigger_out, 1'b0);
        end_test(1, "id and reset state", errs_before);
    endtask

    task automatic hit_spacing();
        timestamp_t first_ts;
        timestamp_t second_ts;
        bus_word_t  rd;
        int         gap;
        int         errs_before;
        errs_before = errors;
        // 4 to 19 cycles keeps 2 high and 2 low
        gap = 4 + int'(lfsr_bits(4));
        hit_train(4'b0001, 2, gap);
        wait_not_empty(0);
        read_head(0, first_ts);
        wb_write(`TDC_REG_POP, 32'h1);
        read_head(0, second_ts);
        check_value("head_ts[0] delta", second_ts - first_ts, timestamp_t'(gap));
        wb_write(`TDC_REG_POP, 32'h1);
        wb_read(`TDC_REG_STATUS, rd);
        check_value("wb_dat_r status", rd, status_word(4'h0, 4'hf));
        end_test(2, "hit spacing", errs_before);
    endtask

    task automatic channel_independence();
        timestamp_t ts1;
        timestamp_t ts3;
        bus_word_t  rd;
        int         errs_before;
        errs_before = errors;
        hit_train(4'b1010, 1, 4);
        wait_not_empty(1);
        wait_not_empty(3);
        read_head(1, ts1);
        read_head(3, ts3);
        check_value("head_ts[3]", ts3, ts1);
        wb_read(`TDC_REG_STATUS, rd);
        check_value("wb_dat_r status", rd, status_word(4'h0, 4'b0101));
        // both pops in one write
        wb_write(`TDC_REG_POP, 32'ha);
        wb_read(`TDC_REG_STATUS, rd);
        check_value("wb_dat_r status", rd, status_word(4'h0, 4'hf));
        end_test(3, "channel independence", errs_before);
    endtask

    task automatic trigger_capture();
        timestamp_t trig;
        timestamp_t head;
        bus_word_t  rd;
        int         errs_before;
        errs_before = errors;
        // hit sampled two edges ahead of the write, so the trigger
        // edge and the end of the hit pulse share one clock edge
        @(negedge clk200);
        hit_in[2] = 1'b1;
        @(negedge clk200);
        wb_write(`TDC_REG_CTRL, 32'h1);
        hit_in[2] = 1'b0;
        wait_not_empty(2);
        read_trig(trig);
        read_head(2, head);
        check_value("trig_ts", trig, head);
        check_value("trigger_out", trigger_out, 1'b1);
        wb_read(`TDC_REG_CTRL, rd);
        check_value("wb_dat_r ctrl", rd, 32'h1);
        wb_write(`TDC_REG_POP, 32'h4);
        end_test(4, "trigger capture", errs_before);
    endtask

    task automatic full_backpressure();
        timestamp_t first_ts;
        timestamp_t ts;
        bus_word_t  rd;
        int         gap;
        int         errs_before;
        errs_before = errors;
        gap = 5;
        first_ts = '0;
        // two hits more than the FIFO holds, the last two are lost
        hit_train(4'b0010, `TDC_FIFO_DEPTH + 2, gap);
        wb_read(`TDC_REG_STATUS, rd);
        check_value("wb_dat_r status", rd, status_word(4'b0010, 4'b1101));
        for (int i = 0; i < `TDC_FIFO_DEPTH; i++)
        begin
            read_head(1, ts);
            if (i == 0)
                first_ts = ts;
            else
                check_value("head_ts[1]", ts, first_ts + timestamp_t'(i * gap));
            wb_write(`TDC_REG_POP, 32'h2);
        end
        wb_read(`TDC_REG_STATUS, rd);
        check_value("wb_dat_r status", rd, status_word(4'h0, 4'hf));
        end_test(5, "full back-pressure", errs_before);
    endtask

    task automatic reset_clears_all();
        timestamp_t trig;
        bus_word_t  rd;
        int         errs_before;
        errs_before = errors;
        // leave an entry behind so the reset has something to clear
        hit_train(4'b0001, 1, 4);
        wait_not_empty(0);
        @(negedge clk200);
        counter_reset = 1'b1;
        repeat (4) @(negedge clk200);
        counter_reset = 1'b0;
        wb_read(`TDC_REG_STATUS, rd);
        check_value("wb_dat_r status", rd, status_word(4'h0, 4'hf));
        read_trig(trig);
        check_value("trig_ts", trig, 64'h0);
        check_value("trigger_out", trigger_out, 1'b0);
        end_test(6, "counter reset", errs_before);
    endtask

    ////////////////////////////////////////////////////////////////////////
    // sequence
    ////////////////////////////////////////////////////////////////////////

    initial
    begin
        counter_reset = 1'b1;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_adr        = '0;
        wb_dat_w      = '0;
        hit_in        = '0;
        repeat (4) @(posedge clk200);
        @(negedge clk200);
        counter_reset = 1'b0;

        id_and_reset_state();
        hit_spacing();
        channel_independence();
        trigger_capture();
        full_backpressure();
        reset_clears_all();

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: verilog/channel_fifo.sv
`timescale 1ns/1ns
`include "tdc_defs.svh"

module channel_fifo
    import tdc_pkg::*;
#(
    parameter int DEPTH = `TDC_FIFO_DEPTH
)
(
    input  logic       clk200,
    input  logic       counter_reset,
    input  logic       wr_req,
    input  timestamp_t ts_in,
    input  logic       rd_req,
    output timestamp_t head_ts,
    output logic       empty,
    output logic       full
);

    // index bits into the storage array
    localparam int addr_bits = $clog2(DEPTH);

    // timestamp storage
    timestamp_t mem [DEPTH];

    // pointers carry one wrap bit above the index
    logic [addr_bits:0] wr_ptr;
    logic [addr_bits:0] rd_ptr;

    // qualified requests
    logic do_wr;
    logic do_rd;

    ////////////////////////////////////////////////////////////////////////
    // flags and request gating
    ////////////////////////////////////////////////////////////////////////

    // same index and same lap means nothing stored
    assign empty = (wr_ptr == rd_ptr);
    // same index, writer one lap ahead
    assign full  = (wr_ptr[addr_bits] != rd_ptr[addr_bits]) &&
                   (wr_ptr[addr_bits-1:0] == rd_ptr[addr_bits-1:0]);

    // a hit into a full FIFO is lost
    assign do_wr = wr_req && !full;
    // pop of an empty FIFO does nothing
    assign do_rd = rd_req && !empty;

    ////////////////////////////////////////////////////////////////////////
    // pointers
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk200)
    begin
        if (counter_reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (do_wr)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // storage write
    always_ff @(posedge clk200)
    begin
        if (do_wr)
        begin
            mem[wr_ptr[addr_bits-1:0]] <= ts_in;
        end
    end

    // oldest entry, visible without read latency
    assign head_ts = mem[rd_ptr[addr_bits-1:0]];

endmodule

// File: verilog/hit_sync.sv
`timescale 1ns/1ns

module hit_sync
    import tdc_pkg::*;
(
    input  logic       clk200,
    input  logic       counter_reset,
    input  chan_mask_t hit_in,
    output chan_mask_t hit_edge
);

    // first synchronizer stage, may go metastable
    chan_mask_t sync_meta;
    // second stage, safe to use in clk200 logic
    chan_mask_t sync_hit;
    // synced value one cycle back, for edge detection
    chan_mask_t sync_prev;

    ////////////////////////////////////////////////////////////////////////
    // double flop plus rising edge detect, all channels in parallel
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk200)
    begin
        if (counter_reset)
        begin
            sync_meta <= '0;
            sync_hit  <= '0;
            sync_prev <= '0;
            hit_edge  <= '0;
        end
        else
        begin
            sync_meta <= hit_in;
            sync_hit  <= sync_meta;
            sync_prev <= sync_hit;
            // registered pulse, one cycle per low-to-high transition
            // lands two edges after hit_in is first sampled high
            hit_edge  <= sync_hit & ~sync_prev;
        end
    end

endmodule

// File: verilog/tdc_pkg.sv
`include "tdc_defs.svh"

package tdc_pkg;

    // raw value of the 64-bit time counter
    typedef logic [`TDC_TS_WIDTH-1:0] timestamp_t;

    // one bit per hit channel
    typedef logic [`TDC_CHANNELS-1:0] chan_mask_t;

    // wishbone data and word address
    typedef logic [31:0] bus_word_t;
    typedef logic [`TDC_ADR_WIDTH-1:0] bus_adr_t;

    // read/write pointer of a default-depth FIFO
    // extra top bit tells a full FIFO from an empty one
    typedef logic [$clog2(`TDC_FIFO_DEPTH):0] fifo_ptr_t;

    // wishbone slave handshake
    typedef enum logic
    {
        st_idle,
        st_ack
    } wb_state_t;

endpackage

// File: verilog/tdc_top.sv
`timescale 1ns/1ns
`include "tdc_defs.svh"

module tdc_top
    import tdc_pkg::*;
(
    input  logic       clk200,
    input  logic       counter_reset,
    // wishbone classic slave
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  bus_adr_t   wb_adr,
    input  bus_word_t  wb_dat_w,
    output bus_word_t  wb_dat_r,
    output logic       wb_ack,
    // asynchronous hit inputs and trigger pin
    input  chan_mask_t hit_in,
    output logic       trigger_out
);

    // synced single-cycle hit pulses
    chan_mask_t hit_edge;
    // live count and captured trigger time
    timestamp_t now_ts;
    timestamp_t trig_ts;
    // per-channel FIFO outputs
    timestamp_t head_ts [`TDC_CHANNELS];
    chan_mask_t fifo_empty;
    chan_mask_t fifo_full;
    // pop strobes from the bus
    chan_mask_t pop;

    ////////////////////////////////////////////////////////////////////////
    // hit path, sync then stamp then readout
    ////////////////////////////////////////////////////////////////////////

    hit_sync u_hit_sync (
        .clk200        (clk200),
        .counter_reset (counter_reset),
        .hit_in        (hit_in),
        .hit_edge      (hit_edge)
    );

    timestamp_unit u_timestamp_unit (
        .clk200        (clk200),
        .counter_reset (counter_reset),
        .trigger_out   (trigger_out),
        .now_ts        (now_ts),
        .trig_ts       (trig_ts)
    );

    // one FIFO per channel, all fed from the same counter
    for (genvar c = 0; c < `TDC_CHANNELS; c++)
    begin : g_chan
        channel_fifo u_channel_fifo (
            .clk200        (clk200),
            .counter_reset (counter_reset),
            .wr_req        (hit_edge[c]),
            .ts_in         (now_ts),
            .rd_req        (pop[c]),
            .head_ts       (head_ts[c]),
            .empty         (fifo_empty[c]),
            .full          (fifo_full[c])
        );
    end

    wb_readout u_wb_readout (
        .clk200        (clk200),
        .counter_reset (counter_reset),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat_w      (wb_dat_w),
        .wb_dat_r      (wb_dat_r),
        .wb_ack        (wb_ack),
        .trig_ts       (trig_ts),
        .head_ts       (head_ts),
        .fifo_empty    (fifo_empty),
        .fifo_full     (fifo_full),
        .trigger_out   (trigger_out),
        .pop           (pop)
    );

endmodule

// File: verilog/timestamp_unit.sv
`timescale 1ns/1ns

module timestamp_unit
    import tdc_pkg::*;
(
    input  logic       clk200,
    input  logic       counter_reset,
    input  logic       trigger_out,
    output timestamp_t now_ts,
    output timestamp_t trig_ts
);

    // free-running time base
    timestamp_t count;
    // trigger pin one cycle back
    logic       trig_q;

    ////////////////////////////////////////////////////////////////////////
    // counter and trigger capture
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk200)
    begin
        if (counter_reset)
        begin
            count   <= '0;
            trig_q  <= 1'b0;
            trig_ts <= '0;
        end
        else
        begin
            // counts every cycle, wraps after 2^64
            count  <= count + timestamp_t'(1);
            trig_q <= trigger_out;
            // latch on the edge that first sees the trigger high
            // same sample point as a FIFO write ending on this edge
            if (trigger_out && !trig_q)
            begin
                trig_ts <= count;
            end
        end
    end

    // every channel FIFO stores this value on its write edge
    assign now_ts = count;

endmodule

// File: verilog/wb_readout.sv
`timescale 1ns/1ns
`include "tdc_defs.svh"

module wb_readout
    import tdc_pkg::*;
(
    input  logic       clk200,
    input  logic       counter_reset,
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  bus_adr_t   wb_adr,
    input  bus_word_t  wb_dat_w,
    output bus_word_t  wb_dat_r,
    output logic       wb_ack,
    input  timestamp_t trig_ts,
    input  timestamp_t head_ts [`TDC_CHANNELS],
    input  chan_mask_t fifo_empty,
    input  chan_mask_t fifo_full,
    output logic       trigger_out,
    output chan_mask_t pop
);

    // handshake state
    wb_state_t state;
    // new access seen while idle
    logic      start;
    // register map output for the current address
    bus_word_t rd_word;

    ////////////////////////////////////////////////////////////////////////
    // register map, read side
    ////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        // unmapped and write-only addresses read zero
        rd_word = '0;
        case (wb_adr)
            `TDC_REG_ID:
                rd_word = `TDC_ID_WORD;
            `TDC_REG_TRIG_HI:
                rd_word = trig_ts[`TDC_TS_WIDTH-1:32];
            `TDC_REG_TRIG_LO:
                rd_word = trig_ts[31:0];
            `TDC_REG_STATUS:
                rd_word = bus_word_t'({fifo_full, fifo_empty});
            `TDC_REG_CTRL:
                rd_word = bus_word_t'(trigger_out);
            default:
                rd_word = '0;
        endcase
        // FIFO heads, two words per channel, high word first
        for (int c = 0; c < `TDC_CHANNELS; c++)
        begin
            if (wb_adr == bus_adr_t'(`TDC_REG_HEAD_BASE + 2 * c))
            begin
                rd_word = head_ts[c][`TDC_TS_WIDTH-1:32];
            end
            if (wb_adr == bus_adr_t'(`TDC_REG_HEAD_BASE + 2 * c + 1))
            begin
                rd_word = head_ts[c][31:0];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // handshake FSM and write side
    ////////////////////////////////////////////////////////////////////////

    // accesses are only taken from idle, so ack is always followed by a gap
    assign start = (state == st_idle) && wb_cyc && wb_stb;

    always_ff @(posedge clk200)
    begin
        if (counter_reset)
        begin
            state       <= st_idle;
            trigger_out <= 1'b0;
            pop         <= '0;
        end
        else
        begin
            // pop bits last for the ack cycle only
            pop <= '0;
            case (state)
                st_idle:
                begin
                    if (start)
                    begin
                        state <= st_ack;
                        if (wb_we && wb_adr == `TDC_REG_CTRL)
                        begin
                            trigger_out <= wb_dat_w[0];
                        end
                        if (wb_we && wb_adr == `TDC_REG_POP)
                        begin
                            pop <= wb_dat_w[`TDC_CHANNELS-1:0];
                        end
                    end
                end
                st_ack:
                begin
                    // master drops stb on ack, back to idle for one cycle
                    state <= st_idle;
                end
                default:
                begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // read data is captured with the access and held through ack
    always_ff @(posedge clk200)
    begin
        if (start && !wb_we)
        begin
            wb_dat_r <= rd_word;
        end
    end

    // ack is high exactly while in the ack state
    assign wb_ack = (state == st_ack);

endmodule
